// ==== masku_pkg.sv ====
`default_nettype none

package masku_pkg;

  // Lane organisation
  localparam int unsigned NR_LANES = 4;
  localparam int unsigned ELEN     = 64;
  // One strobe per byte of a lane word
  localparam int unsigned STRB_W   = ELEN / 8;

  // A beat is one word from every lane
  localparam int unsigned BEAT_BITS  = NR_LANES * ELEN;
  localparam int unsigned BEAT_SHIFT = $clog2(BEAT_BITS);

  // Vector register geometry
  localparam int unsigned VLEN          = 1024;
  localparam int unsigned NR_VREGS      = 32;
  localparam int unsigned BEATS_PER_REG = VLEN / BEAT_BITS;
  localparam int unsigned BEAT_IDX_W    = $clog2(BEATS_PER_REG);

  // Vector length counts 1 to VLEN, so one extra bit
  localparam int unsigned VLEN_W  = $clog2(VLEN) + 1;
  // Register number concatenated with beat index
  localparam int unsigned VADDR_W = $clog2(NR_VREGS) + BEAT_IDX_W;

  // Result queue sizing
  localparam int unsigned RESULT_QUEUE_DEPTH = 2;
  localparam int unsigned RQ_PTR_W           = $clog2(RESULT_QUEUE_DEPTH);
  // Occupancy must reach DEPTH itself
  localparam int unsigned RQ_CNT_W           = RQ_PTR_W + 1;

  // Instruction ids handed out by the sequencer
  localparam int unsigned NR_VINSN = 8;

  typedef logic [ELEN-1:0]             elen_t;
  typedef logic [STRB_W-1:0]           strb_t;
  typedef logic [$clog2(NR_VINSN)-1:0] vid_t;
  typedef logic [$clog2(NR_VREGS)-1:0] vreg_t;
  typedef logic [VLEN_W-1:0]           vlen_t;
  typedef logic [VADDR_W-1:0]          vaddr_t;

  // One lane's write-back payload
  typedef struct packed {
    vid_t   id;
    vaddr_t addr;
    elen_t  wdata;
    strb_t  be;
  } result_t;

endpackage

`default_nettype wire

// ==== masku_issue.sv ====
`timescale 1ns/1ps
`default_nettype none

module masku_issue (
  input  logic                                         clk_i,
  input  logic                                         rst_ni,
  // Sequencer request
  input  logic                                         req_valid_i,
  input  masku_pkg::vid_t                              req_id_i,
  input  masku_pkg::vreg_t                             req_vd_i,
  input  masku_pkg::vlen_t                             req_vl_i,
  // Instruction still committing
  input  logic                                         busy_i,
  // Lane operands, A is the computed result, M the old destination
  input  masku_pkg::elen_t [masku_pkg::NR_LANES-1:0]   operand_a_i,
  input  logic             [masku_pkg::NR_LANES-1:0]   operand_a_valid_i,
  input  masku_pkg::elen_t [masku_pkg::NR_LANES-1:0]   operand_m_i,
  input  logic             [masku_pkg::NR_LANES-1:0]   operand_m_valid_i,
  // Result queue back-pressure
  input  logic                                         full_i,
  output logic                                         req_ready_o,
  output logic             [masku_pkg::NR_LANES-1:0]   operand_ready_o,
  // Accept pulse to the commit side
  output logic                                         accept_o,
  output masku_pkg::vid_t                              accept_id_o,
  output masku_pkg::vlen_t                             accept_vl_o,
  // Merged beat into the result queue
  output logic                                         push_o,
  output masku_pkg::result_t [masku_pkg::NR_LANES-1:0] push_data_o
);

  import masku_pkg::*;

  // Accepted instruction
  vid_t  id_q;
  vreg_t vd_q;
  vlen_t vl_q;

  // Bits still to be issued
  vlen_t issue_cnt_q, issue_cnt_d;

  logic                  issue_valid;
  logic                  consume;
  vlen_t                 issued_bits;
  logic [BEAT_IDX_W-1:0] beat_idx;
  vaddr_t                beat_addr;
  logic [BEAT_BITS-1:0]  bit_en;

  // Only one instruction in flight
  assign req_ready_o = !busy_i;
  assign accept_o    = req_valid_i && req_ready_o;
  assign accept_id_o = req_id_i;
  assign accept_vl_o = req_vl_i;

  assign issue_valid = (issue_cnt_q != '0);

  // Need both channels from every lane and a free queue slot
  assign consume = issue_valid && (&operand_a_valid_i) && (&operand_m_valid_i) && !full_i;

  // All lanes are released together
  assign operand_ready_o = {NR_LANES{consume}};
  assign push_o          = consume;

  // Issued bits are always whole beats, so the upper bits give the index
  assign issued_bits = vl_q - issue_cnt_q;
  assign beat_idx    = issued_bits[BEAT_SHIFT +: BEAT_IDX_W];

  // vd times beats per register plus beat index
  assign beat_addr = vaddr_t'(vd_q * BEATS_PER_REG + beat_idx);

  // Bit enable covers the bits below the remaining count
  always_comb begin
    bit_en = '0;
    if (issue_cnt_q >= vlen_t'(BEAT_BITS)) begin
      bit_en = '1;
    end else begin
      bit_en[issue_cnt_q[BEAT_SHIFT-1:0]] = 1'b1;
      // Single set bit minus one gives the low mask
      bit_en = bit_en - 1'b1;
    end
  end

  // Lane l holds bits l*ELEN upwards in plain order
  for (genvar l = 0; l < NR_LANES; l++) begin : gen_lane
    elen_t lane_en;
    strb_t lane_be;

    assign lane_en = bit_en[l*ELEN +: ELEN];

    // Byte is written when its lowest bit is enabled
    for (genvar b = 0; b < STRB_W; b++) begin : gen_be
      assign lane_be[b] = lane_en[b*(ELEN/STRB_W)];
    end

    // Tail bits keep the old destination value
    assign push_data_o[l] = '{
      id:    id_q,
      addr:  beat_addr,
      wdata: (operand_a_i[l] & lane_en) | (operand_m_i[l] & ~lane_en),
      be:    lane_be
    };
  end

  // Remaining count update
  always_comb begin
    issue_cnt_d = issue_cnt_q;
    if (accept_o) begin
      issue_cnt_d = req_vl_i;
    end else if (consume) begin
      // Saturate on the last partial beat
      if (issue_cnt_q > vlen_t'(BEAT_BITS)) begin
        issue_cnt_d = issue_cnt_q - vlen_t'(BEAT_BITS);
      end else begin
        issue_cnt_d = '0;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      issue_cnt_q <= '0;
    end else begin
      issue_cnt_q <= issue_cnt_d;
    end
  end

  // Instruction fields, loaded on accept
  always_ff @(posedge clk_i) begin
    if (accept_o) begin
      id_q <= req_id_i;
      vd_q <= req_vd_i;
      vl_q <= req_vl_i;
    end
  end

endmodule

`default_nettype wire

// ==== masku_result_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

module masku_result_queue (
  input  logic                                         clk_i,
  input  logic                                         rst_ni,
  // Merged beat from the producer
  input  logic                                         push_i,
  input  masku_pkg::result_t [masku_pkg::NR_LANES-1:0] push_data_i,
  // Per-lane write grants
  input  logic               [masku_pkg::NR_LANES-1:0] result_gnt_i,
  output logic                                         full_o,
  output logic                                         pop_o,
  // Per-lane write requests
  output logic               [masku_pkg::NR_LANES-1:0] result_req_o,
  output masku_pkg::vid_t    [masku_pkg::NR_LANES-1:0] result_id_o,
  output masku_pkg::vaddr_t  [masku_pkg::NR_LANES-1:0] result_addr_o,
  output masku_pkg::elen_t   [masku_pkg::NR_LANES-1:0] result_wdata_o,
  output masku_pkg::strb_t   [masku_pkg::NR_LANES-1:0] result_be_o
);

  import masku_pkg::*;

  // Entry storage, one payload per lane
  result_t [RESULT_QUEUE_DEPTH-1:0][NR_LANES-1:0] entry_q;

  // Lane still waiting for its grant
  logic [RESULT_QUEUE_DEPTH-1:0][NR_LANES-1:0] valid_q, valid_d;

  // Pointers are shared by all lanes
  logic [RQ_PTR_W-1:0] wr_ptr_q, wr_ptr_d;
  logic [RQ_PTR_W-1:0] rd_ptr_q, rd_ptr_d;
  logic [RQ_CNT_W-1:0] cnt_q, cnt_d;

  logic                empty;
  logic [NR_LANES-1:0] head_left;

  // Wrap at the last entry
  function automatic logic [RQ_PTR_W-1:0] ptr_inc(input logic [RQ_PTR_W-1:0] ptr);
    if (ptr == RQ_PTR_W'(RESULT_QUEUE_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign full_o = (cnt_q == RQ_CNT_W'(RESULT_QUEUE_DEPTH));
  assign empty  = (cnt_q == '0);

  // Head entry drives every lane
  for (genvar l = 0; l < NR_LANES; l++) begin : gen_lane_out
    assign result_req_o[l]   = valid_q[rd_ptr_q][l];
    assign result_id_o[l]    = entry_q[rd_ptr_q][l].id;
    assign result_addr_o[l]  = entry_q[rd_ptr_q][l].addr;
    assign result_wdata_o[l] = entry_q[rd_ptr_q][l].wdata;
    assign result_be_o[l]    = entry_q[rd_ptr_q][l].be;
  end

  // Lanes of the head entry not granted yet, counting this cycle
  assign head_left = result_req_o & ~result_gnt_i;

  // Free the head once the last lane takes its word
  assign pop_o = !empty && (head_left == '0);

  always_comb begin
    valid_d  = valid_q;
    wr_ptr_d = wr_ptr_q;
    rd_ptr_d = rd_ptr_q;

    // Grants clear lanes one by one, others keep their state
    valid_d[rd_ptr_q] = head_left;

    if (pop_o) begin
      rd_ptr_d = ptr_inc(rd_ptr_q);
    end

    // New beat requests on all lanes
    if (push_i) begin
      valid_d[wr_ptr_q] = '1;
      wr_ptr_d          = ptr_inc(wr_ptr_q);
    end

    cnt_d = cnt_q + RQ_CNT_W'(push_i) - RQ_CNT_W'(pop_o);
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q  <= '0;
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      valid_q  <= valid_d;
      wr_ptr_q <= wr_ptr_d;
      rd_ptr_q <= rd_ptr_d;
      cnt_q    <= cnt_d;
    end
  end

  // Payload written on push only
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      entry_q[wr_ptr_q] <= push_data_i;
    end
  end

endmodule

`default_nettype wire

// ==== masku_commit.sv ====
`timescale 1ns/1ps
`default_nettype none

module masku_commit (
  input  logic             clk_i,
  input  logic             rst_ni,
  // Instruction accepted by the producer
  input  logic             accept_i,
  input  masku_pkg::vid_t  accept_id_i,
  input  masku_pkg::vlen_t accept_vl_i,
  // Beat fully written back by all lanes
  input  logic             pop_i,
  output logic             busy_o,
  output logic             done_o,
  output masku_pkg::vid_t  done_id_o
);

  import masku_pkg::*;

  logic  busy_q;
  vid_t  id_q;
  // Bits not yet written back
  vlen_t commit_cnt_q;
  vlen_t commit_cnt_next;
  logic  done_q;
  vid_t  done_id_q;

  // Count after this pop, saturating on the partial tail beat
  assign commit_cnt_next = (commit_cnt_q > vlen_t'(BEAT_BITS)) ?
                           commit_cnt_q - vlen_t'(BEAT_BITS) : '0;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q       <= 1'b0;
      commit_cnt_q <= '0;
      done_q       <= 1'b0;
      done_id_q    <= '0;
    end else begin
      // Done is a single-cycle pulse
      done_q <= 1'b0;
      if (accept_i) begin
        busy_q       <= 1'b1;
        commit_cnt_q <= accept_vl_i;
      end else if (busy_q && pop_i) begin
        commit_cnt_q <= commit_cnt_next;
        // Last beat granted, so report and free the unit together
        if (commit_cnt_next == '0) begin
          busy_q    <= 1'b0;
          done_q    <= 1'b1;
          done_id_q <= id_q;
        end
      end
    end
  end

  // Id of the instruction in flight
  always_ff @(posedge clk_i) begin
    if (accept_i) begin
      id_q <= accept_id_i;
    end
  end

  assign busy_o    = busy_q;
  assign done_o    = done_q;
  assign done_id_o = done_id_q;

endmodule

`default_nettype wire

// ==== masku_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module masku_top (
  input  logic                                        clk_i,
  input  logic                                        rst_ni,
  // Sequencer
  input  logic                                        req_valid_i,
  input  masku_pkg::vid_t                             req_id_i,
  input  masku_pkg::vreg_t                            req_vd_i,
  input  masku_pkg::vlen_t                            req_vl_i,
  output logic                                        req_ready_o,
  output logic                                        done_o,
  output masku_pkg::vid_t                             done_id_o,
  // Lane operands
  input  masku_pkg::elen_t  [masku_pkg::NR_LANES-1:0] operand_a_i,
  input  logic              [masku_pkg::NR_LANES-1:0] operand_a_valid_i,
  input  masku_pkg::elen_t  [masku_pkg::NR_LANES-1:0] operand_m_i,
  input  logic              [masku_pkg::NR_LANES-1:0] operand_m_valid_i,
  output logic              [masku_pkg::NR_LANES-1:0] operand_ready_o,
  // Lane results
  output logic              [masku_pkg::NR_LANES-1:0] result_req_o,
  output masku_pkg::vid_t   [masku_pkg::NR_LANES-1:0] result_id_o,
  output masku_pkg::vaddr_t [masku_pkg::NR_LANES-1:0] result_addr_o,
  output masku_pkg::elen_t  [masku_pkg::NR_LANES-1:0] result_wdata_o,
  output masku_pkg::strb_t  [masku_pkg::NR_LANES-1:0] result_be_o,
  input  logic              [masku_pkg::NR_LANES-1:0] result_gnt_i
);

  import masku_pkg::*;

  // Producer to commit
  logic  accept;
  vid_t  accept_id;
  vlen_t accept_vl;
  logic  busy;

  // Producer to queue and back
  logic                     push;
  result_t [NR_LANES-1:0]   push_data;
  logic                     full;
  // Queue to commit
  logic                     pop;

  // Holds the instruction and merges operand beats
  masku_issue i_issue (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .req_valid_i       (req_valid_i),
    .req_id_i          (req_id_i),
    .req_vd_i          (req_vd_i),
    .req_vl_i          (req_vl_i),
    .busy_i            (busy),
    .operand_a_i       (operand_a_i),
    .operand_a_valid_i (operand_a_valid_i),
    .operand_m_i       (operand_m_i),
    .operand_m_valid_i (operand_m_valid_i),
    .full_i            (full),
    .req_ready_o       (req_ready_o),
    .operand_ready_o   (operand_ready_o),
    .accept_o          (accept),
    .accept_id_o       (accept_id),
    .accept_vl_o       (accept_vl),
    .push_o            (push),
    .push_data_o       (push_data)
  );

  // Two beats of per-lane write-back
  masku_result_queue i_result_queue (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .push_i         (push),
    .push_data_i    (push_data),
    .result_gnt_i   (result_gnt_i),
    .full_o         (full),
    .pop_o          (pop),
    .result_req_o   (result_req_o),
    .result_id_o    (result_id_o),
    .result_addr_o  (result_addr_o),
    .result_wdata_o (result_wdata_o),
    .result_be_o    (result_be_o)
  );

  // Tracks written-back bits and reports completion
  masku_commit i_commit (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .accept_i    (accept),
    .accept_id_i (accept_id),
    .accept_vl_i (accept_vl),
    .pop_i       (pop),
    .busy_o      (busy),
    .done_o      (done_o),
    .done_id_o   (done_id_o)
  );

endmodule

`default_nettype wire

// ==== tb_masku_ref.svh ====
`ifndef TB_MASKU_REF_SVH
`define TB_MASKU_REF_SVH

// Bits below the remaining count come from A, the tail keeps M
function automatic elen_t merged_word(elen_t a, elen_t m, int remaining, int lane);
  elen_t w;
  for (int i = 0; i < ELEN; i++) begin
    w[i] = (lane * ELEN + i < remaining) ? a[i] : m[i];
  end
  return w;
endfunction

// A byte is written when its first bit lies inside the vector
function automatic strb_t byte_enables(int remaining, int lane);
  strb_t be;
  for (int b = 0; b < STRB_W; b++) begin
    be[b] = (lane * ELEN + b * 8 < remaining);
  end
  return be;
endfunction

// Registers are laid out beat after beat
function automatic vaddr_t beat_address(int vd, int beat);
  return vaddr_t'(vd * BEATS_PER_REG + beat);
endfunction

// Expected write-back of one lane for one beat
function automatic result_t expected_result(vid_t id, int vd, int vl, int beat, int lane,
                                            elen_t a, elen_t m);
  result_t r;
  int      remaining;
  remaining = vl - beat * BEAT_BITS;
  r.id      = id;
  r.addr    = beat_address(vd, beat);
  r.wdata   = merged_word(a, m, remaining, lane);
  r.be      = byte_enables(remaining, lane);
  return r;
endfunction

`endif

// ==== tb_masku.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_masku;

  import masku_pkg::*;

  localparam int N_INSN    = 12;
  localparam int MAX_BEATS = N_INSN * BEATS_PER_REG;

  // One beat as seen by all lanes
  typedef result_t [NR_LANES-1:0] beat_t;

  logic                  clk_i = 1'b0;
  logic                  rst_ni;
  logic                  req_valid_i;
  logic                  req_ready_o;
  vid_t                  req_id_i;
  vreg_t                 req_vd_i;
  vlen_t                 req_vl_i;
  logic                  done_o;
  vid_t                  done_id_o;
  elen_t [NR_LANES-1:0]  operand_a_i;
  elen_t [NR_LANES-1:0]  operand_m_i;
  logic  [NR_LANES-1:0]  operand_a_valid_i;
  logic  [NR_LANES-1:0]  operand_m_valid_i;
  logic  [NR_LANES-1:0]  operand_ready_o;
  logic  [NR_LANES-1:0]  result_req_o;
  logic  [NR_LANES-1:0]  result_gnt_i;
  vid_t  [NR_LANES-1:0]  result_id_o;
  vaddr_t [NR_LANES-1:0] result_addr_o;
  elen_t [NR_LANES-1:0]  result_wdata_o;
  strb_t [NR_LANES-1:0]  result_be_o;

  // Stimulus tables drawn once before reset
  integer seed;
  vid_t   insn_id  [N_INSN];
  int     insn_vd  [N_INSN];
  int     insn_vl  [N_INSN];
  int     beat_end [N_INSN];
  elen_t  opa_mem  [MAX_BEATS][NR_LANES];
  elen_t  opm_mem  [MAX_BEATS][NR_LANES];
  int     gnt_dly  [MAX_BEATS][NR_LANES];
  int     gap_mem  [MAX_BEATS];
  int     total_beats;
  beat_t  exp_q[$];

  // Scoreboard state
  logic                   in_flight = 1'b0;
  int                     done_cnt = 0;
  int                     popped = 0;
  int                     held = 0;
  logic [NR_LANES-1:0]    lane_took = '0;
  logic [NR_LANES-1:0]    hold_prev = '0;
  result_t [NR_LANES-1:0] result_prev;
  // Grant generator state
  logic [NR_LANES-1:0]  gnt_next = '0;
  int                   lane_beat [NR_LANES];
  int                   dly_left  [NR_LANES];

  masku_top i_dut (.*);

  always #5 clk_i = ~clk_i;

  `include "tb_masku_ref.svh"

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("=== FAIL ===");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input logic [63:0] exp,
                                 input logic [63:0] act);
    abort_run($sformatf("ERR t=%0t %s expected 0x%0h actual 0x%0h", $time, name, exp, act));
  endtask

  task automatic build_stimulus();
    beat_t beat;
    int    k;
    k = 0;
    for (int i = 0; i < N_INSN; i++) begin
      insn_id[i] = vid_t'($random(seed));
      insn_vd[i] = $random(seed) & 31;
      // Whole registers first and now and then, random tails otherwise
      if (i < 2 || i % 4 == 3) begin
        insn_vl[i] = BEAT_BITS * (($random(seed) & 3) + 1);
      end else begin
        insn_vl[i] = ($random(seed) & 1023) + 1;
      end
      for (int b = 0; b * BEAT_BITS < insn_vl[i]; b++) begin
        for (int l = 0; l < NR_LANES; l++) begin
          opa_mem[k][l][63:32] = $random(seed);
          opa_mem[k][l][31:0]  = $random(seed);
          opm_mem[k][l][63:32] = $random(seed);
          opm_mem[k][l][31:0]  = $random(seed);
          gnt_dly[k][l]        = $random(seed) & 7;
          beat[l] = expected_result(insn_id[i], insn_vd[i], insn_vl[i], b, l,
                                    opa_mem[k][l], opm_mem[k][l]);
        end
        // Occasional holes in the operand stream
        gap_mem[k] = (($random(seed) & 3) == 0) ? 2 : 0;
        exp_q.push_back(beat);
        k++;
      end
      beat_end[i] = k;
    end
    total_beats = k;
  endtask

  task automatic drive_requests();
    for (int i = 0; i < N_INSN; i++) begin
      @(posedge clk_i);
      req_valid_i <= 1'b1;
      req_id_i    <= insn_id[i];
      req_vd_i    <= vreg_t'(insn_vd[i]);
      req_vl_i    <= vlen_t'(insn_vl[i]);
      // Offered while the previous one is still in flight
      do @(negedge clk_i); while (!req_ready_o);
      @(posedge clk_i);
      req_valid_i <= 1'b0;
    end
  endtask

  task automatic drive_operands();
    @(posedge clk_i);
    for (int k = 0; k < total_beats; k++) begin
      if (gap_mem[k] != 0) begin
        // One lane still lacks its old destination word
        operand_a_valid_i <= '1;
        operand_m_valid_i <= ~(NR_LANES'(1) << (k % NR_LANES));
        repeat (gap_mem[k]) @(posedge clk_i);
      end
      for (int l = 0; l < NR_LANES; l++) begin
        operand_a_i[l] <= opa_mem[k][l];
        operand_m_i[l] <= opm_mem[k][l];
      end
      operand_a_valid_i <= '1;
      operand_m_valid_i <= '1;
      // Valids stay up until the beat is taken
      do @(negedge clk_i); while (!operand_ready_o[0]);
      @(posedge clk_i);
    end
    operand_a_valid_i <= '0;
    operand_m_valid_i <= '0;
  endtask

  // Per-lane grant after a random number of request cycles
  always @(negedge clk_i) begin
    for (int l = 0; l < NR_LANES; l++) begin
      gnt_next[l] = 1'b0;
      if (!rst_ni) begin
        lane_beat[l] = 0;
        dly_left[l]  = gnt_dly[0][l];
      end else if (result_gnt_i[l]) begin
        lane_beat[l]++;
        dly_left[l] = gnt_dly[lane_beat[l] % MAX_BEATS][l];
      end else if (result_req_o[l]) begin
        if (dly_left[l] == 0) begin
          gnt_next[l] = 1'b1;
        end else begin
          dly_left[l]--;
        end
      end
    end
  end

  always @(posedge clk_i) begin
    result_gnt_i <= gnt_next;
  end

  // Response checks on settled values at the falling edge
  always @(negedge clk_i) begin
    if (rst_ni) begin
      // Idle means ready, and ready comes back in the done cycle
      assert (req_ready_o == (!in_flight || done_o))
        else report_mismatch("req_ready_o", !in_flight || done_o, req_ready_o);
      if (done_o) begin
        assert (in_flight) else abort_run("done_o pulsed with no instruction in flight");
        assert (done_id_o == insn_id[done_cnt])
          else report_mismatch("done_id_o", insn_id[done_cnt], done_id_o);
        assert (popped == beat_end[done_cnt])
          else abort_run("done_o came before every lane granted every beat");
        in_flight = 1'b0;
        done_cnt++;
      end
      if (req_valid_i && req_ready_o) begin
        in_flight = 1'b1;
      end
      // All lanes are released together
      assert (operand_ready_o == '0 || operand_ready_o == '1)
        else report_mismatch("operand_ready_o", {NR_LANES{operand_ready_o[0]}},
                             operand_ready_o);
      if (held == RESULT_QUEUE_DEPTH) begin
        assert (operand_ready_o == '0)
          else report_mismatch("operand_ready_o", 0, operand_ready_o);
      end
      if (operand_ready_o[0]) begin
        assert (&{operand_a_valid_i, operand_m_valid_i})
          else abort_run("Operands were taken before all lanes were valid");
        held++;
      end
      for (int l = 0; l < NR_LANES; l++) begin
        // Request and payload stay put until granted
        if (hold_prev[l]) begin
          assert (result_req_o[l])
            else abort_run($sformatf("Lane %0d dropped its request without a grant", l));
          assert (result_id_o[l] == result_prev[l].id)
            else report_mismatch($sformatf("result_id_o[%0d]", l), result_prev[l].id,
                                 result_id_o[l]);
          assert (result_addr_o[l] == result_prev[l].addr)
            else report_mismatch($sformatf("result_addr_o[%0d]", l), result_prev[l].addr,
                                 result_addr_o[l]);
          assert (result_wdata_o[l] == result_prev[l].wdata)
            else report_mismatch($sformatf("result_wdata_o[%0d]", l), result_prev[l].wdata,
                                 result_wdata_o[l]);
          assert (result_be_o[l] == result_prev[l].be)
            else report_mismatch($sformatf("result_be_o[%0d]", l), result_prev[l].be,
                                 result_be_o[l]);
        end
        hold_prev[l]         = result_req_o[l] && !result_gnt_i[l];
        result_prev[l].id    = result_id_o[l];
        result_prev[l].addr  = result_addr_o[l];
        result_prev[l].wdata = result_wdata_o[l];
        result_prev[l].be    = result_be_o[l];
        if (result_req_o[l] && result_gnt_i[l]) begin
          assert (!lane_took[l] && exp_q.size() != 0)
            else abort_run($sformatf("Lane %0d wrote a beat that was not expected", l));
          assert (result_id_o[l] == exp_q[0][l].id)
            else report_mismatch($sformatf("result_id_o[%0d]", l), exp_q[0][l].id,
                                 result_id_o[l]);
          assert (result_addr_o[l] == exp_q[0][l].addr)
            else report_mismatch($sformatf("result_addr_o[%0d]", l), exp_q[0][l].addr,
                                 result_addr_o[l]);
          assert (result_wdata_o[l] == exp_q[0][l].wdata)
            else report_mismatch($sformatf("result_wdata_o[%0d]", l), exp_q[0][l].wdata,
                                 result_wdata_o[l]);
          assert (result_be_o[l] == exp_q[0][l].be)
            else report_mismatch($sformatf("result_be_o[%0d]", l), exp_q[0][l].be,
                                 result_be_o[l]);
          lane_took[l] = 1'b1;
        end
      end
      // Head beat retires once every lane has it
      if (lane_took == '1) begin
        void'(exp_q.pop_front());
        lane_took = '0;
        popped++;
        held--;
      end
    end
  end

  initial begin
    repeat (N_INSN * 64 + 200) @(posedge clk_i);
    abort_run("Timeout: the unit stopped making progress");
  end

  initial begin
    seed              = 32'hb64dca6a;
    rst_ni            = 1'b0;
    req_valid_i       = 1'b0;
    req_id_i          = '0;
    req_vd_i          = '0;
    req_vl_i          = '0;
    operand_a_i       = '0;
    operand_m_i       = '0;
    operand_a_valid_i = '0;
    operand_m_valid_i = '0;
    result_gnt_i      = '0;
    build_stimulus();
    repeat (2) @(posedge clk_i);
    rst_ni <= 1'b1;
    fork
      drive_requests();
      drive_operands();
    join
    wait (done_cnt == N_INSN);
    repeat (4) @(posedge clk_i);
    if (exp_q.size() == 0 && held == 0 && result_req_o == '0) begin
      $display("=== PASS ===");
      $finish;
    end else begin
      abort_run("Run ended with beats left over or a lane still requesting");
    end
  end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+.
masku_pkg.sv
masku_issue.sv
masku_result_queue.sv
masku_commit.sv
masku_top.sv
tb_masku.sv
